/* hw/dma_pkg.sv */
`default_nettype none

package dma_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int unsigned ADDR_WIDTH = 16;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned LEN_WIDTH  = 8;

    // Buffer slots and also the number of read credits
    localparam int unsigned BUF_DEPTH    = 4;
    // Holds a count from 0 up to BUF_DEPTH
    localparam int unsigned CREDIT_WIDTH = $clog2(BUF_DEPTH + 1);

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0] dma_addr_t;
    typedef logic [DATA_WIDTH-1:0] dma_data_t;
    // Transfer length or beat index in words
    typedef logic [LEN_WIDTH-1:0]  dma_len_t;
    typedef logic [1:0]            dma_err_t;

    // Response codes where read errors win over write errors
    localparam dma_err_t ERR_NONE     = 2'd0;
    localparam dma_err_t ERR_ZERO_LEN = 2'd1;
    localparam dma_err_t ERR_READ     = 2'd2;
    localparam dma_err_t ERR_WRITE    = 2'd3;

endpackage : dma_pkg

`default_nettype wire

/* hw/dma_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_fsm import dma_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     arst_n_i,
    input  wire logic     req_valid_i,
    input  wire dma_len_t req_len_i,
    input  wire logic     done_i,
    input  wire logic     rd_err_i,
    input  wire logic     wr_err_i,
    input  wire logic     rsp_ready_i,
    output logic          req_ready_o,
    output logic          start_o,
    output logic          rsp_valid_o,
    output dma_err_t      rsp_err_o,
    output logic          busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        RESP
    } state_e;

    state_e   state_q;
    dma_err_t err_q;
    logic     accept;
    logic     len_zero;

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i & req_ready_o;
    assign len_zero    = (req_len_i == '0);

    // Beat counter loads on the acceptance edge, while the request is still on the port
    assign start_o = accept & ~len_zero;

    assign rsp_valid_o = (state_q == RESP);
    assign rsp_err_o   = err_q;
    assign busy_o      = (state_q != IDLE);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            err_q   <= ERR_NONE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept && len_zero) begin
                        state_q <= RESP;
                        err_q   <= ERR_ZERO_LEN;
                    end else if (accept) begin
                        state_q <= RUN;
                    end
                end
                RUN: begin
                    // Sticky flags already include the last write response here
                    if (done_i) begin
                        state_q <= RESP;
                        if (rd_err_i) err_q <= ERR_READ;
                        else if (wr_err_i) err_q <= ERR_WRITE;
                        else err_q <= ERR_NONE;
                    end
                end
                RESP: begin
                    if (rsp_ready_i) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Response holds until it is taken
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_err_o));

endmodule : dma_ctrl_fsm

`default_nettype wire

/* hw/dma_beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_beat_counter import dma_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      start_i,
    input  wire dma_addr_t src_i,
    input  wire dma_addr_t dst_i,
    input  wire dma_len_t  len_i,
    input  wire logic      rd_issue_i,
    input  wire logic      wr_issue_i,
    input  wire logic      wr_rsp_i,
    output dma_addr_t      rd_addr_o,
    output dma_addr_t      wr_addr_o,
    output logic           rd_left_o,
    output logic           wr_left_o,
    output logic           done_o
);

    dma_addr_t rd_addr_q;
    dma_addr_t wr_addr_q;
    dma_len_t  rd_cnt_q;
    dma_len_t  wr_cnt_q;
    // Write responses still expected
    dma_len_t  rsp_cnt_q;
    logic      done_q;

    // Addresses wrap naturally at ADDR_WIDTH
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rd_addr_q <= src_i;
            wr_addr_q <= dst_i;
        end else begin
            if (rd_issue_i) rd_addr_q <= rd_addr_q + dma_addr_t'(1);
            if (wr_issue_i) wr_addr_q <= wr_addr_q + dma_addr_t'(1);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_cnt_q  <= '0;
            wr_cnt_q  <= '0;
            rsp_cnt_q <= '0;
            done_q    <= 1'b0;
        end else if (start_i) begin
            rd_cnt_q  <= len_i;
            wr_cnt_q  <= len_i;
            rsp_cnt_q <= len_i;
            done_q    <= 1'b0;
        end else begin
            if (rd_issue_i) rd_cnt_q <= rd_cnt_q - dma_len_t'(1);
            if (wr_issue_i) wr_cnt_q <= wr_cnt_q - dma_len_t'(1);
            if (wr_rsp_i) begin
                rsp_cnt_q <= rsp_cnt_q - dma_len_t'(1);
                if (rsp_cnt_q == dma_len_t'(1)) done_q <= 1'b1;
            end
        end
    end

    assign rd_addr_o = rd_addr_q;
    assign wr_addr_o = wr_addr_q;
    assign rd_left_o = (rd_cnt_q != '0);
    assign wr_left_o = (wr_cnt_q != '0);
    assign done_o    = done_q;

    // Read and write units never run past the transfer length
    a_no_extra_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_issue_i |-> rd_left_o) and (wr_issue_i |-> wr_left_o));

endmodule : dma_beat_counter

`default_nettype wire

/* hw/dma_read_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_read_unit import dma_pkg::*; (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic start_i,
    input  wire logic rd_left_i,
    input  wire logic rd_ready_i,
    input  wire logic credit_i,
    input  wire logic rd_rsp_valid_i,
    input  wire logic rd_rsp_err_i,
    output logic      rd_valid_o,
    output logic      rd_issue_o,
    output logic      rd_err_o
);

    logic [CREDIT_WIDTH-1:0] credit_q;
    logic                    err_q;

    // Holding one credit per free buffer slot keeps returned data from finding it full
    assign rd_valid_o = rd_left_i & (credit_q != '0);
    assign rd_issue_o = rd_valid_o & rd_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= CREDIT_WIDTH'(BUF_DEPTH);
        end else begin
            credit_q <= credit_q + CREDIT_WIDTH'(credit_i) - CREDIT_WIDTH'(rd_issue_o);
        end
    end

    // Sticky read error that leaves the copy running to the last beat
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else if (start_i) begin
            err_q <= 1'b0;
        end else if (rd_rsp_valid_i && rd_rsp_err_i) begin
            err_q <= 1'b1;
        end
    end

    assign rd_err_o = err_q;

    // Buffer never returns more credits than it has slots
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        credit_q <= CREDIT_WIDTH'(BUF_DEPTH));

endmodule : dma_read_unit

`default_nettype wire

/* hw/dma_data_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_data_buffer import dma_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      push_i,
    input  wire dma_data_t data_i,
    input  wire logic      pop_i,
    output logic           valid_o,
    output dma_data_t      data_o,
    output logic           credit_o
);

    dma_data_t                      mem_q [BUF_DEPTH];
    logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(BUF_DEPTH)-1:0]   rd_ptr_q;
    logic [CREDIT_WIDTH-1:0]        count_q;

    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wr_ptr_q] <= data_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                if (wr_ptr_q == $clog2(BUF_DEPTH)'(BUF_DEPTH - 1)) wr_ptr_q <= '0;
                else wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                if (rd_ptr_q == $clog2(BUF_DEPTH)'(BUF_DEPTH - 1)) rd_ptr_q <= '0;
                else rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CREDIT_WIDTH'(push_i) - CREDIT_WIDTH'(pop_i);
        end
    end

    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    // Each freed slot goes straight back to the read side
    assign credit_o = pop_i;

    // Credit scheme must keep returning data inside the buffer
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_i |-> count_q != CREDIT_WIDTH'(BUF_DEPTH));

endmodule : dma_data_buffer

`default_nettype wire

/* hw/dma_write_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_write_unit (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic start_i,
    input  wire logic wr_left_i,
    input  wire logic buf_valid_i,
    input  wire logic wr_ready_i,
    input  wire logic wr_rsp_valid_i,
    input  wire logic wr_rsp_err_i,
    output logic      wr_valid_o,
    output logic      wr_issue_o,
    output logic      wr_err_o
);

    logic err_q;

    // Write as soon as a word sits in the buffer
    assign wr_valid_o = buf_valid_i & wr_left_i;
    // Accepted write also pops the buffer
    assign wr_issue_o = wr_valid_o & wr_ready_i;

    // ------------------------------------------------------------------------
    // Write error capture
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else if (start_i) begin
            err_q <= 1'b0;
        end else if (wr_rsp_valid_i && wr_rsp_err_i) begin
            err_q <= 1'b1;
        end
    end

    assign wr_err_o = err_q;

endmodule : dma_write_unit

`default_nettype wire

/* hw/dma_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_backend import dma_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    // Transfer request
    input  wire logic      req_valid_i,
    input  wire dma_addr_t req_src_i,
    input  wire dma_addr_t req_dst_i,
    input  wire dma_len_t  req_len_i,
    output logic           req_ready_o,
    // Transfer response
    output logic           rsp_valid_o,
    output dma_err_t       rsp_err_o,
    input  wire logic      rsp_ready_i,
    // Read port
    output logic           rd_valid_o,
    output dma_addr_t      rd_addr_o,
    input  wire logic      rd_ready_i,
    input  wire logic      rd_rsp_valid_i,
    input  wire dma_data_t rd_rsp_data_i,
    input  wire logic      rd_rsp_err_i,
    // Write port
    output logic           wr_valid_o,
    output dma_addr_t      wr_addr_o,
    output dma_data_t      wr_data_o,
    input  wire logic      wr_ready_i,
    input  wire logic      wr_rsp_valid_i,
    input  wire logic      wr_rsp_err_i,
    output logic           busy_o
);

    logic start;
    logic done;
    logic rd_left;
    logic wr_left;
    logic rd_issue;
    logic wr_issue;
    logic rd_err;
    logic wr_err;
    logic credit;
    logic buf_valid;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    dma_ctrl_fsm i_ctrl (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .req_valid_i ( req_valid_i ),
        .req_len_i   ( req_len_i   ),
        .done_i      ( done        ),
        .rd_err_i    ( rd_err      ),
        .wr_err_i    ( wr_err      ),
        .rsp_ready_i ( rsp_ready_i ),
        .req_ready_o ( req_ready_o ),
        .start_o     ( start       ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_err_o   ( rsp_err_o   ),
        .busy_o      ( busy_o      )
    );

    dma_beat_counter i_beats (
        .clk_i      ( clk_i          ),
        .arst_n_i   ( arst_n_i       ),
        .start_i    ( start          ),
        .src_i      ( req_src_i      ),
        .dst_i      ( req_dst_i      ),
        .len_i      ( req_len_i      ),
        .rd_issue_i ( rd_issue       ),
        .wr_issue_i ( wr_issue       ),
        .wr_rsp_i   ( wr_rsp_valid_i ),
        .rd_addr_o  ( rd_addr_o      ),
        .wr_addr_o  ( wr_addr_o      ),
        .rd_left_o  ( rd_left        ),
        .wr_left_o  ( wr_left        ),
        .done_o     ( done           )
    );

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    dma_read_unit i_read (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .start_i        ( start          ),
        .rd_left_i      ( rd_left        ),
        .rd_ready_i     ( rd_ready_i     ),
        .credit_i       ( credit         ),
        .rd_rsp_valid_i ( rd_rsp_valid_i ),
        .rd_rsp_err_i   ( rd_rsp_err_i   ),
        .rd_valid_o     ( rd_valid_o     ),
        .rd_issue_o     ( rd_issue       ),
        .rd_err_o       ( rd_err         )
    );

    // Credits guarantee room for every read word pushed here
    dma_data_buffer i_buffer (
        .clk_i    ( clk_i          ),
        .arst_n_i ( arst_n_i       ),
        .push_i   ( rd_rsp_valid_i ),
        .data_i   ( rd_rsp_data_i  ),
        .pop_i    ( wr_issue       ),
        .valid_o  ( buf_valid      ),
        .data_o   ( wr_data_o      ),
        .credit_o ( credit         )
    );

    dma_write_unit i_write (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .start_i        ( start          ),
        .wr_left_i      ( wr_left        ),
        .buf_valid_i    ( buf_valid      ),
        .wr_ready_i     ( wr_ready_i     ),
        .wr_rsp_valid_i ( wr_rsp_valid_i ),
        .wr_rsp_err_i   ( wr_rsp_err_i   ),
        .wr_valid_o     ( wr_valid_o     ),
        .wr_issue_o     ( wr_issue       ),
        .wr_err_o       ( wr_err         )
    );

endmodule : dma_backend

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held for 16 clock cycles and released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* verif/tb_dma_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_backend import dma_pkg::*; ();

    localparam dma_data_t READ_PATTERN = 32'hA5A5_0000;

    logic      clk;
    logic      arst_n;
    logic      req_valid;
    dma_addr_t req_src;
    dma_addr_t req_dst;
    dma_len_t  req_len;
    logic      req_ready;
    logic      rsp_valid;
    dma_err_t  rsp_err;
    logic      rsp_ready;
    logic      rd_valid;
    dma_addr_t rd_addr;
    logic      rd_ready;
    logic      rd_rsp_valid;
    dma_data_t rd_rsp_data;
    logic      rd_rsp_err;
    logic      wr_valid;
    dma_addr_t wr_addr;
    dma_data_t wr_data;
    logic      wr_ready;
    logic      wr_rsp_valid;
    logic      wr_rsp_err;
    logic      busy;

    // Transfers from the data file
    dma_addr_t t_src [$];
    dma_addr_t t_dst [$];
    dma_len_t  t_len [$];
    int        t_rd_err [$];
    int        t_wr_err [$];

    // Memory model state
    dma_data_t mem_model [dma_addr_t];
    int        rd_due_q [$];
    dma_data_t rd_data_q [$];
    bit        rd_err_q [$];
    int        wr_due_q [$];
    bit        wr_err_q [$];
    dma_addr_t cur_src;
    dma_addr_t cur_dst;
    int        cur_len;
    int        rd_err_idx;
    int        wr_err_idx;
    int        n_rd;
    int        n_wr;
    int        cyc = 0;
    int        wd_cycles = 0;
    int        err_data = 0;
    int        err_addr = 0;
    int        err_code = 0;
    int        err_other = 0;

    tb_clk_gen clk_gen0 (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    dma_backend dut0 (
        .clk_i          ( clk          ),
        .arst_n_i       ( arst_n       ),
        .req_valid_i    ( req_valid    ),
        .req_src_i      ( req_src      ),
        .req_dst_i      ( req_dst      ),
        .req_len_i      ( req_len      ),
        .req_ready_o    ( req_ready    ),
        .rsp_valid_o    ( rsp_valid    ),
        .rsp_err_o      ( rsp_err      ),
        .rsp_ready_i    ( rsp_ready    ),
        .rd_valid_o     ( rd_valid     ),
        .rd_addr_o      ( rd_addr      ),
        .rd_ready_i     ( rd_ready     ),
        .rd_rsp_valid_i ( rd_rsp_valid ),
        .rd_rsp_data_i  ( rd_rsp_data  ),
        .rd_rsp_err_i   ( rd_rsp_err   ),
        .wr_valid_o     ( wr_valid     ),
        .wr_addr_o      ( wr_addr      ),
        .wr_data_o      ( wr_data      ),
        .wr_ready_i     ( wr_ready     ),
        .wr_rsp_valid_i ( wr_rsp_valid ),
        .wr_rsp_err_i   ( wr_rsp_err   ),
        .busy_o         ( busy         )
    );

    // ------------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------------
    task automatic check_data(input dma_data_t got, input dma_data_t exp, input string what);
        if (got !== exp) begin
            err_data++;
            $display("FAILED %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input dma_addr_t got, input dma_addr_t exp, input string what);
        if (got !== exp) begin
            err_addr++;
            $display("FAILED %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input dma_err_t got, input dma_err_t exp, input string what);
        if (got !== exp) begin
            err_code++;
            $display("FAILED %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        err_other++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic print_summary();
        $display("Error counts: data %0d, address %0d, response %0d, other %0d",
                 err_data, err_addr, err_code, err_other);
    endtask

    // Memory content seen by the read port
    function automatic dma_data_t model_word(input dma_addr_t addr);
        return dma_data_t'(addr) ^ READ_PATTERN;
    endfunction

    // Zero length wins over both error kinds and read errors win over write errors
    function automatic dma_err_t expected_code(input int len, input int ri, input int wi);
        if (len == 0) return ERR_ZERO_LEN;
        if (ri < len) return ERR_READ;
        if (wi < len) return ERR_WRITE;
        return ERR_NONE;
    endfunction

    task automatic load_tests();
        int    fd;
        string line;
        int unsigned f_src;
        int unsigned f_dst;
        int unsigned f_len;
        int unsigned f_re;
        int unsigned f_we;
        fd = $fopen("verif/dma_backend_tests.txt", "r");
        if (fd == 0) begin
            report_problem("could not open verif/dma_backend_tests.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h %h", f_src, f_dst, f_len, f_re, f_we) == 5) begin
                    t_src.push_back(dma_addr_t'(f_src));
                    t_dst.push_back(dma_addr_t'(f_dst));
                    t_len.push_back(dma_len_t'(f_len));
                    t_rd_err.push_back(int'(f_re));
                    t_wr_err.push_back(int'(f_we));
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // Memory model step for one clock cycle on the falling edge
    // ------------------------------------------------------------------------
    task automatic step_cycle();
        int due;
        @(negedge clk);
        cyc++;
        rd_ready  = ($urandom % 4) != 0;
        wr_ready  = ($urandom % 4) != 0;
        rsp_ready = rsp_valid && (($urandom % 2) == 0);

        // Handshakes below complete on the next rising edge
        if (rd_valid && rd_ready) begin
            if (n_rd >= cur_len) report_problem("read issued past the transfer length");
            check_addr(rd_addr, cur_src + dma_addr_t'(n_rd),
                       $sformatf("read address %0d", n_rd));
            due = cyc + 1 + int'($urandom % 3);
            if (rd_due_q.size() != 0 && due <= rd_due_q[$]) due = rd_due_q[$] + 1;
            rd_due_q.push_back(due);
            rd_data_q.push_back(model_word(rd_addr));
            rd_err_q.push_back(n_rd == rd_err_idx);
            n_rd++;
        end
        if (wr_valid && wr_ready) begin
            if (n_wr >= cur_len) report_problem("write issued past the transfer length");
            check_addr(wr_addr, cur_dst + dma_addr_t'(n_wr),
                       $sformatf("write address %0d", n_wr));
            mem_model[wr_addr] = wr_data;
            due = cyc + 1 + int'($urandom % 3);
            if (wr_due_q.size() != 0 && due <= wr_due_q[$]) due = wr_due_q[$] + 1;
            wr_due_q.push_back(due);
            wr_err_q.push_back(n_wr == wr_err_idx);
            n_wr++;
        end
        if (n_rd - n_wr > int'(BUF_DEPTH)) begin
            report_problem($sformatf("%0d reads ahead of writes, more than the buffer holds",
                                     n_rd - n_wr));
        end

        // In-order responses with at most one per cycle on each port
        rd_rsp_valid = 1'b0;
        rd_rsp_data  = '0;
        rd_rsp_err   = 1'b0;
        if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
            void'(rd_due_q.pop_front());
            rd_rsp_valid = 1'b1;
            rd_rsp_data  = rd_data_q.pop_front();
            rd_rsp_err   = rd_err_q.pop_front();
        end
        wr_rsp_valid = 1'b0;
        wr_rsp_err   = 1'b0;
        if (wr_due_q.size() != 0 && wr_due_q[0] <= cyc) begin
            void'(wr_due_q.pop_front());
            wr_rsp_valid = 1'b1;
            wr_rsp_err   = wr_err_q.pop_front();
        end
    endtask

    task automatic run_transfer(input int idx);
        dma_err_t  exp_code;
        dma_err_t  held;
        dma_addr_t a;
        bit        seen;
        bit        taken;
        cur_src    = t_src[idx];
        cur_dst    = t_dst[idx];
        cur_len    = int'(t_len[idx]);
        rd_err_idx = t_rd_err[idx];
        wr_err_idx = t_wr_err[idx];
        n_rd       = 0;
        n_wr       = 0;
        mem_model.delete();
        exp_code = expected_code(cur_len, rd_err_idx, wr_err_idx);
        held     = ERR_NONE;
        seen     = 1'b0;
        taken    = 1'b0;

        req_valid = 1'b1;
        req_src   = cur_src;
        req_dst   = cur_dst;
        req_len   = t_len[idx];
        while (!req_ready) step_cycle();
        step_cycle();
        req_valid = 1'b0;
        if (cur_len == 0 && !rsp_valid) begin
            report_problem("zero-length response not presented one cycle after acceptance");
        end

        while (!taken) begin
            if (req_ready) report_problem("req_ready_o high before the response was taken");
            if (!busy) report_problem("busy_o low during a transfer");
            if (rsp_valid) begin
                if (seen && rsp_err !== held) report_problem("response code changed while stalled");
                held  = rsp_err;
                seen  = 1'b1;
                taken = rsp_ready;
            end else if (seen) begin
                report_problem("response withdrawn before it was taken");
            end
            if (!taken) step_cycle();
        end
        check_err(held, exp_code, $sformatf("response code of transfer %0d", idx));
        step_cycle();
        if (!req_ready) report_problem("req_ready_o low after the response was taken");
        if (busy) report_problem("busy_o high after the response was taken");

        if (n_rd != cur_len || n_wr != cur_len) begin
            report_problem($sformatf("transfer %0d: %0d reads and %0d writes for %0d words",
                                     idx, n_rd, n_wr, cur_len));
        end
        if (mem_model.num() != cur_len) begin
            report_problem($sformatf("transfer %0d wrote %0d distinct addresses",
                                     idx, mem_model.num()));
        end
        for (int i = 0; i < cur_len; i++) begin
            a = cur_dst + dma_addr_t'(i);
            if (!mem_model.exists(a)) begin
                report_problem($sformatf("transfer %0d never wrote address %h", idx, a));
            end else begin
                check_data(mem_model[a], model_word(cur_src + dma_addr_t'(i)),
                           $sformatf("word %0d of transfer %0d", i, idx));
            end
        end
    endtask

    initial begin
        int total_words;
        req_valid    = 1'b0;
        req_src      = '0;
        req_dst      = '0;
        req_len      = '0;
        rsp_ready    = 1'b0;
        rd_ready     = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_data  = '0;
        rd_rsp_err   = 1'b0;
        wr_ready     = 1'b0;
        wr_rsp_valid = 1'b0;
        wr_rsp_err   = 1'b0;
        cur_len      = 0;
        rd_err_idx   = -1;
        wr_err_idx   = -1;
        n_rd         = 0;
        n_wr         = 0;
        void'($urandom(47003));
        load_tests();
        if (t_src.size() == 0) begin
            $display("No transfers could be read from the test data file");
            print_summary();
            $display("Checks failed");
            $finish;
        end else begin
            total_words = 0;
            foreach (t_len[i]) total_words += int'(t_len[i]);
            wd_cycles = total_words * 20 + t_src.size() * 50;
            wait (arst_n === 1'b1);
            step_cycle();
            if (rsp_valid || rd_valid || wr_valid || busy || !req_ready) begin
                report_problem("control outputs not in their idle state after reset");
            end
            foreach (t_src[i]) run_transfer(i);
            print_summary();
            if (err_data + err_addr + err_code + err_other == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Watchdog armed once the test length is known
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", wd_cycles);
        print_summary();
        $display("Checks failed");
        $finish;
    end

endmodule : tb_dma_backend

`default_nettype wire

/* verif/dma_backend_tests.txt */
# Columns in hex: source, destination, length in words, read-error word, write-error word
# An error index of ff means that the transfer has no error of that kind
0000 1000 01 ff ff
0010 2000 08 ff ff
0100 0200 10 ff ff
0300 0400 00 ff ff
fffc 3000 08 ff ff
4000 fffa 0c ff ff
5000 6000 06 02 ff
5100 6100 05 ff 04
5200 6200 07 00 03
5300 6300 00 01 ff
7000 7100 20 ff ff
7200 7300 03 02 ff
7400 7500 04 ff 00
8000 8001 40 ff ff
0020 0021 02 ff ff
ff00 ff80 30 1f 10

/* dma_backend.f */
hw/dma_pkg.sv
hw/dma_ctrl_fsm.sv
hw/dma_beat_counter.sv
hw/dma_read_unit.sv
hw/dma_data_buffer.sv
hw/dma_write_unit.sv
hw/dma_backend.sv
verif/tb_clk_gen.sv
verif/tb_dma_backend.sv

/* Bender.yml */
package:
  name: dma_backend

sources:
  - files:
      - hw/dma_pkg.sv
      - hw/dma_ctrl_fsm.sv
      - hw/dma_beat_counter.sv
      - hw/dma_read_unit.sv
      - hw/dma_data_buffer.sv
      - hw/dma_write_unit.sv
      - hw/dma_backend.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_dma_backend.sv
